// ==== logic/game_render_pkg.sv ====
package game_render_pkg;

	// Screen and board geometry
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	localparam int GRID_DIM = 4;
	localparam int CELL_W = 160;
	localparam int CELL_H = 120;
	localparam int LINE_W = 2;

	typedef logic [9:0]   coord_t;
	typedef logic [1:0]   cell_idx_t;
	typedef logic [7:0]   cell_off_t;
	typedef logic [11:0]  tile_t;
	typedef logic [191:0] board_t;
	typedef logic [7:0]   channel_t;
	typedef logic [23:0]  color_t;
	typedef logic [3:0]   digit_t;

	typedef enum logic [1:0] {MODE_PLAY, MODE_LOSE, MODE_WIN, MODE_BLANK} screen_mode_t;

	typedef enum logic [2:0] {
		KIND_GRID, KIND_EMPTY, KIND_DIGIT, KIND_TILE_BG, KIND_INVALID, KIND_OVERRIDE
	} pixel_kind_t;

	// Stroke rows and digit box inside a cell
	localparam int DIGIT_TOP = 30;
	localparam int DIGIT_MID = 60;
	localparam int DIGIT_BOT = 90;
	localparam int DIGIT_W = 20;
	localparam int DIGIT_PITCH = 30;

	// First digit left edge for 1..4 digits
	localparam cell_off_t DIGIT_START [4] = '{8'd70, 8'd55, 8'd40, 8'd25};

	// Bit order: top, upper right, lower right, bottom, lower left, upper left, middle
	localparam logic [6:0] SEGMENT_MAP [10] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
	};

	// {count[2:0], first digit, second, third, fourth} by exponent
	localparam logic [18:0] TILE_DIGITS [1:11] = '{
		{3'd1, 16'h2000}, {3'd1, 16'h4000}, {3'd1, 16'h8000},
		{3'd2, 16'h1600}, {3'd2, 16'h3200}, {3'd2, 16'h6400},
		{3'd3, 16'h1280}, {3'd3, 16'h2560}, {3'd3, 16'h5120},
		{3'd4, 16'h1024}, {3'd4, 16'h2048}
	};

	localparam color_t COLOR_WHITE = 24'hFF_FF_FF;
	localparam color_t COLOR_RED   = 24'hFF_00_00;
	localparam color_t COLOR_GREEN = 24'h00_FF_00;
	localparam color_t COLOR_BLUE  = 24'h00_00_FF;
	localparam color_t COLOR_BLACK = 24'h00_00_00;

endpackage

// ==== logic/cell_pos_if.sv ====
`timescale 1ns/10ps

interface cell_pos_if
	import game_render_pkg::*;
();

	cell_idx_t    row;
	cell_idx_t    col;
	cell_off_t    off_x;
	cell_off_t    off_y;
	logic         grid_line;
	screen_mode_t mode;

	modport locator (output row, col, off_x, off_y, grid_line, mode);

	modport consumer (input row, col, off_x, off_y, grid_line, mode);

endinterface

// ==== logic/digit_segments.sv ====
`timescale 1ns/10ps

module digit_segments
	import game_render_pkg::*;
(
	input  digit_t    digit,
	input  cell_off_t dx,
	input  cell_off_t dy,
	output logic      hit
);

	logic       in_box;
	logic       on_left;
	logic       on_right;
	logic       upper;
	logic       lower;
	logic [6:0] seg_on;
	logic [6:0] lit;

	assign in_box = (dx <= DIGIT_W);
	assign on_left = (dx == '0);
	assign on_right = (dx == DIGIT_W);
	assign upper = (dy >= DIGIT_TOP) && (dy <= DIGIT_MID);
	assign lower = (dy >= DIGIT_MID) && (dy <= DIGIT_BOT);

	always_comb begin
		seg_on[0] = in_box && (dy == DIGIT_TOP);
		seg_on[1] = on_right && upper;
		seg_on[2] = on_right && lower;
		seg_on[3] = in_box && (dy == DIGIT_BOT);
		seg_on[4] = on_left && lower;
		seg_on[5] = on_left && upper;
		seg_on[6] = in_box && (dy == DIGIT_MID);
	end

	// Non-decimal codes light nothing
	assign lit = (digit <= 4'd9) ? SEGMENT_MAP[digit] : '0;
	assign hit = |(seg_on & lit);

endmodule

// ==== logic/cell_locator.sv ====
`timescale 1ns/10ps

module cell_locator
	import game_render_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  coord_t     x,
	input  coord_t     y,
	input  logic       lose,
	input  logic       win,
	cell_pos_if.locator pos
);

	cell_idx_t    row_c;
	cell_idx_t    col_c;
	cell_off_t    off_x_c;
	cell_off_t    off_y_c;
	logic         grid_c;
	screen_mode_t mode_c;

	always_comb begin
		col_c = cell_idx_t'(x / CELL_W);
		row_c = cell_idx_t'(y / CELL_H);
		off_x_c = cell_off_t'(x % CELL_W);
		off_y_c = cell_off_t'(y % CELL_H);
		grid_c = (off_x_c < LINE_W) || (off_x_c >= CELL_W - LINE_W) ||
			(off_y_c < LINE_W) || (off_y_c >= CELL_H - LINE_W);
	end

	// Off-screen wins over the game-over flags, lose over win
	always_comb begin
		if (x >= SCREEN_W || y >= SCREEN_H) begin
			mode_c = MODE_BLANK;
		end else if (lose) begin
			mode_c = MODE_LOSE;
		end else if (win) begin
			mode_c = MODE_WIN;
		end else begin
			mode_c = MODE_PLAY;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos.mode <= MODE_BLANK;
		end else begin
			pos.mode <= mode_c;
		end
	end

	always_ff @(posedge clk) begin
		pos.row <= row_c;
		pos.col <= col_c;
		pos.off_x <= off_x_c;
		pos.off_y <= off_y_c;
		pos.grid_line <= grid_c;
	end

	// Cell and offset must rebuild the sampled on-screen position
	a_offset_in_cell: assert property (@(posedge clk) disable iff (reset)
		pos.mode != MODE_BLANK |-> (pos.off_x < CELL_W) && (pos.off_y < CELL_H) &&
			(int'(pos.col) * CELL_W + int'(pos.off_x) == int'($past(x))) &&
			(int'(pos.row) * CELL_H + int'(pos.off_y) == int'($past(y))));

endmodule

// ==== logic/tile_glyph.sv ====
`timescale 1ns/10ps

module tile_glyph
	import game_render_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	cell_pos_if.consumer  pos,
	input  board_t        board,
	output pixel_kind_t   kind,
	output screen_mode_t  mode
);

	localparam int TILE_BITS = $bits(tile_t);

	int          tile_idx;
	tile_t       tile;
	logic [3:0]  tile_exp;
	logic        tile_valid;
	logic [18:0] entry;
	logic [2:0]  digit_count;
	cell_off_t   start_x;
	cell_off_t   box_left [4];
	cell_off_t   box_dx [4];
	digit_t      digit [4];
	logic [3:0]  seg_hit;
	logic [3:0]  lane_en;
	pixel_kind_t kind_c;

	always_comb begin
		tile_idx = int'(pos.row) * GRID_DIM + int'(pos.col);
		tile = board[TILE_BITS * tile_idx +: TILE_BITS];
	end

	// Only 2^1 .. 2^11 count as tiles
	always_comb begin
		tile_exp = '0;
		for (int e = 1; e < TILE_BITS; e++) begin
			if (tile == tile_t'(1 << e)) begin
				tile_exp = 4'(e);
			end
		end
	end

	assign tile_valid = (tile_exp != '0);
	assign entry = tile_valid ? TILE_DIGITS[tile_exp] : '0;
	assign digit_count = entry[18:16];
	assign start_x = DIGIT_START[2'(digit_count - 3'd1)];

	for (genvar i = 0; i < 4; i++) begin : g_digit
		assign digit[i] = entry[15 - 4 * i -: 4];
		assign box_left[i] = cell_off_t'(start_x + i * DIGIT_PITCH);
		// Left of the box wraps past DIGIT_W and never hits
		assign box_dx[i] = pos.off_x - box_left[i];
		assign lane_en[i] = (digit_count > 3'(i));

		digit_segments i_segments (
			.digit(digit[i]),
			.dx(box_dx[i]),
			.dy(pos.off_y),
			.hit(seg_hit[i])
		);
	end

	always_comb begin
		if (pos.mode != MODE_PLAY) begin
			kind_c = KIND_OVERRIDE;
		end else if (pos.grid_line) begin
			kind_c = KIND_GRID;
		end else if (tile == '0) begin
			kind_c = KIND_EMPTY;
		end else if (!tile_valid) begin
			kind_c = KIND_INVALID;
		end else if (|(seg_hit & lane_en)) begin
			kind_c = KIND_DIGIT;
		end else begin
			kind_c = KIND_TILE_BG;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kind <= KIND_OVERRIDE;
			mode <= MODE_BLANK;
		end else begin
			kind <= kind_c;
			mode <= pos.mode;
		end
	end

	a_digit_count: assert property (@(posedge clk) disable iff (reset)
		(pos.mode == MODE_PLAY) && tile_valid |-> digit_count inside {[3'd1:3'd4]});

endmodule

// ==== logic/pixel_color.sv ====
`timescale 1ns/10ps

module pixel_color
	import game_render_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  pixel_kind_t  kind,
	input  screen_mode_t mode,
	output channel_t     red,
	output channel_t     green,
	output channel_t     blue
);

	color_t color_c;

	always_comb begin
		case (kind)
			KIND_OVERRIDE: begin
				case (mode)
					MODE_LOSE: color_c = COLOR_RED;
					MODE_WIN:  color_c = COLOR_GREEN;
					default:   color_c = COLOR_BLACK;
				endcase
			end
			KIND_GRID:     color_c = COLOR_WHITE;
			KIND_EMPTY:    color_c = COLOR_GREEN;
			KIND_DIGIT:    color_c = COLOR_RED;
			KIND_TILE_BG:  color_c = COLOR_BLUE;
			default:       color_c = COLOR_RED;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			{red, green, blue} <= COLOR_BLACK;
		end else begin
			{red, green, blue} <= color_c;
		end
	end

	// First colour after release comes from the reset state upstream
	a_black_after_reset: assert property (@(posedge clk)
		reset ##1 !reset |=> (red == '0) && (green == '0) && (blue == '0));

endmodule

// ==== logic/board_renderer.sv ====
`timescale 1ns/10ps

module board_renderer
	import game_render_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  coord_t   x,
	input  coord_t   y,
	input  board_t   board,
	input  logic     lose,
	input  logic     win,
	output channel_t red,
	output channel_t green,
	output channel_t blue
);

	pixel_kind_t  kind;
	screen_mode_t mode;

	cell_pos_if pos ();

	cell_locator i_locator (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.lose(lose),
		.win(win),
		.pos(pos.locator)
	);

	tile_glyph i_glyph (
		.clk(clk),
		.reset(reset),
		.pos(pos.consumer),
		.board(board),
		.kind(kind),
		.mode(mode)
	);

	pixel_color i_color (
		.clk(clk),
		.reset(reset),
		.kind(kind),
		.mode(mode),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Held over three rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== tb/board_renderer_tb.sv ====
`timescale 1ns/10ps

module board_renderer_tb
	import game_render_pkg::*;
();

	localparam string TEST_FILE = "tb/board_renderer_tests.txt";
	localparam int CLK_PERIOD = 20;

	logic     clk;
	logic     reset;
	coord_t   x;
	coord_t   y;
	board_t   board;
	logic     lose;
	logic     win;
	channel_t red;
	channel_t green;
	channel_t blue;

	string  lines [$];
	int     num_lines = 0;
	color_t expect_q [$];
	bit     check_q [$];

	tb_clock_gen i_clock (
		.clk(clk),
		.reset(reset)
	);

	board_renderer i_dut (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.board(board),
		.lose(lose),
		.win(win),
		.red(red),
		.green(green),
		.blue(blue)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_channel(input string name, input channel_t expected,
			input channel_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("[ERROR] %0d ns: %s expected %02h, got %02h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_color(input color_t expected, input color_t actual);
		compare_channel("red", expected[23:16], actual[23:16]);
		compare_channel("green", expected[15:8], actual[15:8]);
		compare_channel("blue", expected[7:0], actual[7:0]);
	endtask

	// Check the pixel issued three falling edges ago, then drive the next one
	task automatic tick(input bit valid, input coord_t px, input coord_t py,
			input logic lose_in, input logic win_in, input color_t expected);
		color_t due;
		@(negedge clk);
		if (check_q.size() == 3) begin
			due = expect_q.pop_front();
			if (check_q.pop_front()) begin
				check_color(due, {red, green, blue});
			end
		end
		x = px;
		y = py;
		lose = lose_in;
		win = win_in;
		check_q.push_back(valid);
		expect_q.push_back(expected);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) tick(1'b0, x, y, lose, win, COLOR_BLACK);
	endtask

	// Drain pixels still using the old board before switching
	task automatic apply_board(input board_t value);
		idle_cycles(3);
		board = value;
		idle_cycles(3);
	endtask

	task automatic run_line(input string line);
		board_t value;
		int     f [7];
		string  body;
		body = line.substr(2, line.len() - 1);
		if (line.getc(0) == "B" && $sscanf(body, "%h", value) == 1) begin
			apply_board(value);
		end else if (line.getc(0) == "V" && $sscanf(body, "%d %d %d %d %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6]) == 7) begin
			tick(1'b1, coord_t'(f[0]), coord_t'(f[1]), f[2][0], f[3][0],
				{channel_t'(f[4]), channel_t'(f[5]), channel_t'(f[6])});
		end else begin
			fail_run({"Malformed line in the test vector file: ", line});
		end
	endtask

	task automatic load_tests();
		int    fd;
		string line;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			fail_run({"Cannot open the test vector file ", TEST_FILE});
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		wait (num_lines > 0);
		#(num_lines * 6 * CLK_PERIOD + 1000);
		fail_run($sformatf("Timeout: %0d test lines did not finish in time", num_lines));
	end

	initial begin
		x = '0;
		y = '0;
		board = '0;
		lose = 1'b0;
		win = 1'b0;
		load_tests();
		if (lines.size() == 0) begin
			fail_run("The test vector file holds no tests");
		end
		num_lines = lines.size();
		@(negedge reset);
		check_color(COLOR_BLACK, {red, green, blue});
		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		idle_cycles(3);
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== tb/board_renderer_tests.txt ====
# B <board, 48 hex digits, tile 15 first and tile 0 last>
# V <x> <y> <lose> <win> <red> <green> <blue>, x to win in decimal, colours in hex
B 000000000000000000000400004064003000800080010002
V 0 50 0 0 FF FF FF
V 159 50 0 0 FF FF FF
V 160 50 0 0 FF FF FF
V 50 119 0 0 FF FF FF
V 70 30 0 0 FF 00 00
V 70 75 0 0 FF 00 00
V 90 45 0 0 FF 00 00
V 90 75 0 0 00 00 FF
V 235 45 0 0 FF 00 00
V 245 45 0 0 FF 00 00
V 265 45 0 0 00 00 FF
V 392 60 0 0 FF 00 00
V 365 60 0 0 00 00 FF
V 540 60 0 0 00 00 FF
V 535 60 0 0 FF 00 00
V 615 90 0 0 FF 00 00
V 80 180 0 0 00 FF 00
V 240 180 0 0 FF 00 00
V 400 200 0 0 FF 00 00
V 639 479 0 0 FF FF FF
V 100 100 1 0 FF 00 00
V 160 50 1 0 FF 00 00
V 160 50 0 1 00 FF 00
V 80 180 1 1 FF 00 00
V 640 10 1 0 00 00 00
V 10 480 1 1 00 00 00
B FFF000000000000000000000000000000000000000000003
V 80 50 0 0 FF 00 00
V 240 50 0 0 00 FF 00
V 560 400 0 0 FF 00 00

// ==== sources.f ====
logic/game_render_pkg.sv
logic/cell_pos_if.sv
logic/digit_segments.sv
logic/cell_locator.sv
logic/tile_glyph.sv
logic/pixel_color.sv
logic/board_renderer.sv
tb/tb_clock_gen.sv
tb/board_renderer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= board_renderer_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' sources.f)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): sources.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
